// File: ecc_wb_top.f
+incdir+hw
hw/ecc_pkg.sv
hw/ecc_encoder.sv
hw/ecc_corrector.sv
hw/ecc_wb_regs.sv
hw/ecc_result_stage.sv
hw/ecc_wb_top.sv
sim/ecc_wb_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ECC Wishbone testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f ecc_wb_top.f --top-module ecc_wb_tb -o ecc_wb_sim

out=$(./obj_dir/ecc_wb_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Everything OK"; then
    exit 0
else
    exit 1
fi

// File: sim/ecc_wb_tb.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_wb_tb;

    localparam int DW         = `ECC_DATA_W;
    localparam int PW         = `ECC_PAR_W;
    localparam int ACK_LIMIT  = 16;
    localparam int DONE_LIMIT = 32;

    logic                    clk;
    logic                    rst;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`ECC_WB_AW-1:0]   wb_adr;
    logic [`ECC_WB_DW-1:0]   wb_dat_w;
    logic [`ECC_WB_DW/8-1:0] wb_sel;
    logic [`ECC_WB_DW-1:0]   wb_dat_r;
    logic                    wb_ack;
    logic [31:0]             rng_state;
    logic [PW-1:0]           col_tab [DW];  // Reference columns

    ecc_wb_top ecc_wb_top_i (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [DW-1:0] rand_data();
        logic [127:0] w;
        w = {next_rand(), next_rand(), next_rand(), next_rand()};
        return w[DW-1:0];
    endfunction

    // Hamming positions from 3 upward without powers of two
    task automatic build_columns();
        int unsigned p;
        p = 3;
        for (int i = 0; i < DW; i++) begin
            while ((p & (p - 1)) == 0) begin
                p++;
            end
            col_tab[i][PW-2:0] = p[PW-2:0];
            col_tab[i][PW-1]   = ~^p[PW-2:0];  // Odd column weight
            p++;
        end
    endtask

    function automatic logic [PW-1:0] model_parity(input logic [DW-1:0] d);
        logic [PW-1:0] par;
        par = '0;
        for (int i = 0; i < DW; i++) begin
            if (d[i]) begin
                par = par ^ col_tab[i];
            end
        end
        return par;
    endfunction

    task automatic wb_xfer(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
        int cnt;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= addr;
        wb_dat_w <= wdata;
        cnt = 0;
        @(negedge clk);
        while (!wb_ack && cnt < ACK_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!wb_ack) begin
            abort_run($sformatf("Timeout: no Wishbone ack at address 0x%0h", addr));
        end
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        wb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input logic [7:0] addr, output logic [31:0] data);
        wb_xfer(1'b0, addr, 32'd0, data);
    endtask

    task automatic run_cmd(input ecc_pkg::ecc_op_e op);
        logic [31:0] status;
        int          cnt;
        wb_write(`ECC_ADDR_CMD, {31'd0, op});
        cnt = 0;
        wb_read(`ECC_ADDR_STATUS, status);
        while (!status[`ECC_STAT_DONE_BIT] && cnt < DONE_LIMIT) begin
            wb_read(`ECC_ADDR_STATUS, status);
            cnt++;
        end
        if (!status[`ECC_STAT_DONE_BIT]) begin
            abort_run("Timeout: done bit never set after a command");
        end
    endtask

    // Load inputs, run one command and compare every result register
    task automatic run_case(input logic [DW-1:0] d, input logic [PW-1:0] par,
                            input ecc_pkg::ecc_op_e op, input logic [DW-1:0] exp_d,
                            input logic exp_s, input logic exp_db);
        logic [31:0]  rd;
        logic [127:0] res;
        wb_write(`ECC_ADDR_DATA0, d[31:0]);
        wb_write(`ECC_ADDR_DATA1, d[63:32]);
        wb_write(`ECC_ADDR_DATA2, d[95:64]);
        wb_write(`ECC_ADDR_DATA3, 32'(d[DW-1:96]));
        wb_write(`ECC_ADDR_PAR_IN, 32'(par));
        run_cmd(op);
        res = '0;
        for (int w = 0; w < 4; w++) begin
            wb_read(8'(`ECC_ADDR_RES0 + 4 * w), rd);
            res[32*w +: 32] = rd;
        end
        check_eq("res_data", res, 128'(exp_d));
        wb_read(`ECC_ADDR_RES_PAR, rd);
        check_eq("res_par", 128'(rd), 128'(model_parity(d)));
        wb_read(`ECC_ADDR_STATUS, rd);
        check_eq("status", 128'(rd), 128'({exp_db, exp_s, 1'b1}));
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        wb_read(`ECC_ADDR_STATUS, rd);
        check_eq("status", 128'(rd), 128'd0);
    endtask

    task automatic test_encode_clean();
        logic [DW-1:0] d;
        for (int n = 0; n < 4; n++) begin
            d = rand_data();
            run_case(d, 8'(next_rand()), ecc_pkg::OP_ENCODE, d, 1'b0, 1'b0);
            run_case(d, model_parity(d), ecc_pkg::OP_CHECK, d, 1'b0, 1'b0);
        end
    endtask

    task automatic test_single_data(input int idx);
        logic [DW-1:0] d;
        logic [DW-1:0] flip;
        d         = rand_data();
        flip      = '0;
        flip[idx] = 1'b1;
        run_case(d ^ flip, model_parity(d), ecc_pkg::OP_CHECK, d, 1'b1, 1'b0);
    endtask

    task automatic test_check_and_double();
        logic [DW-1:0] d;
        logic [DW-1:0] flip;
        int            a;
        for (int j = 0; j < PW; j++) begin
            d = rand_data();
            run_case(d, model_parity(d) ^ (8'd1 << j), ecc_pkg::OP_CHECK, d, 1'b1, 1'b0);
        end
        for (int n = 0; n < 4; n++) begin
            d       = rand_data();
            a       = int'(next_rand() % 32'd105);
            flip    = '0;
            flip[a] = 1'b1;
            flip[(a + 1 + int'(next_rand() % 32'd104)) % DW] = 1'b1;  // Distinct second bit
            run_case(d ^ flip, model_parity(d), ecc_pkg::OP_CHECK, d ^ flip, 1'b0, 1'b1);
        end
    endtask

    task automatic test_done_clear();
        logic [31:0] rd;
        wb_write(`ECC_ADDR_DATA0, next_rand());
        wb_read(`ECC_ADDR_STATUS, rd);
        check_eq("done", 128'(rd[`ECC_STAT_DONE_BIT]), 128'd0);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        wb_sel    = '1;
        rng_state = 32'd80124;
        build_columns();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_encode_clean();
        test_single_data(0);
        test_single_data(DW - 1);
        for (int n = 0; n < 6; n++) begin
            test_single_data(int'(next_rand() % 32'd105));
        end
        test_check_and_double();
        test_done_clear();
        $display("Everything OK");
        $finish;
    end

endmodule

// File: hw/ecc_wb_top.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_wb_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`ECC_WB_AW-1:0]   wb_adr,
    input  logic [`ECC_WB_DW-1:0]   wb_dat_w,
    input  logic [`ECC_WB_DW/8-1:0] wb_sel,
    output logic [`ECC_WB_DW-1:0]   wb_dat_r,
    output logic                    wb_ack
);

    ecc_pkg::data_t   data_in;
    ecc_pkg::parity_t par_in;
    ecc_pkg::ecc_op_e op;
    logic             cmd_start;
    logic             clear_done;
    ecc_pkg::parity_t par_gen;
    ecc_pkg::data_t   data_corr;
    logic             sbit_c;
    logic             dbit_c;
    ecc_pkg::data_t   res_data;
    ecc_pkg::parity_t res_par;
    logic             res_sbit;
    logic             res_dbit;
    logic             done;

    ecc_wb_regs ecc_wb_regs_i (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_sel     (wb_sel),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .data_in    (data_in),
        .par_in     (par_in),
        .op         (op),
        .cmd_start  (cmd_start),
        .clear_done (clear_done),
        .res_data   (res_data),
        .res_par    (res_par),
        .sbit       (res_sbit),
        .dbit       (res_dbit),
        .done       (done)
    );

    ecc_encoder ecc_encoder_i (
        .data   (data_in),
        .parity (par_gen)
    );

    ecc_corrector ecc_corrector_i (
        .op       (op),
        .data_in  (data_in),
        .par_in   (par_in),
        .par_gen  (par_gen),
        .data_out (data_corr),
        .sbit     (sbit_c),
        .dbit     (dbit_c)
    );

    ecc_result_stage ecc_result_stage_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_start  (cmd_start),
        .clear_done (clear_done),
        .data_corr  (data_corr),
        .par_gen    (par_gen),
        .sbit_in    (sbit_c),
        .dbit_in    (dbit_c),
        .res_data   (res_data),
        .res_par    (res_par),
        .sbit       (res_sbit),
        .dbit       (res_dbit),
        .done       (done)
    );

endmodule

// File: hw/ecc_result_stage.sv
`timescale 1ns/1ps

module ecc_result_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             cmd_start,
    input  logic             clear_done,
    input  ecc_pkg::data_t   data_corr,
    input  ecc_pkg::parity_t par_gen,
    input  logic             sbit_in,
    input  logic             dbit_in,
    output ecc_pkg::data_t   res_data,
    output ecc_pkg::parity_t res_par,
    output logic             sbit,
    output logic             dbit,
    output logic             done
);

    // Result of the last command, held until the next one
    always_ff @(posedge clk) begin
        if (rst) begin
            res_data <= '0;
            res_par  <= '0;
            sbit     <= 1'b0;
            dbit     <= 1'b0;
        end else if (cmd_start) begin
            res_data <= data_corr;
            res_par  <= par_gen;
            sbit     <= sbit_in;
            dbit     <= dbit_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else if (cmd_start) begin
            done <= 1'b1;
        end else if (clear_done) begin
            done <= 1'b0;  // New input pending
        end
    end

endmodule

// File: hw/ecc_wb_regs.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_wb_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`ECC_WB_AW-1:0]     wb_adr,
    input  logic [`ECC_WB_DW-1:0]     wb_dat_w,
    input  logic [`ECC_WB_DW/8-1:0]   wb_sel,   // Full word writes only
    output logic [`ECC_WB_DW-1:0]     wb_dat_r,
    output logic                      wb_ack,
    output ecc_pkg::data_t            data_in,
    output ecc_pkg::parity_t          par_in,
    output ecc_pkg::ecc_op_e          op,
    output logic                      cmd_start,
    output logic                      clear_done,
    input  ecc_pkg::data_t            res_data,
    input  ecc_pkg::parity_t          res_par,
    input  logic                      sbit,
    input  logic                      dbit,
    input  logic                      done
);

    localparam int HI_W = `ECC_DATA_W - 96;  // Bits held in the top data word

    logic                  req;
    logic                  wr_en;
    logic                  cmd_wr;
    logic [`ECC_WB_DW-1:0] rd_data;

    assign req   = wb_cyc && wb_stb && !wb_ack;
    assign wr_en = req && wb_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            data_in    <= '0;
            par_in     <= '0;
            op         <= ecc_pkg::OP_ENCODE;
            cmd_wr     <= 1'b0;
            cmd_start  <= 1'b0;
            clear_done <= 1'b0;
        end else begin
            wb_ack     <= req;
            cmd_wr     <= 1'b0;
            cmd_start  <= cmd_wr;  // One cycle behind the ack
            clear_done <= 1'b0;
            if (wr_en) begin
                case (wb_adr)
                    `ECC_ADDR_DATA0: begin
                        data_in[31:0] <= wb_dat_w;
                        clear_done    <= 1'b1;
                    end
                    `ECC_ADDR_DATA1: begin
                        data_in[63:32] <= wb_dat_w;
                        clear_done     <= 1'b1;
                    end
                    `ECC_ADDR_DATA2: begin
                        data_in[95:64] <= wb_dat_w;
                        clear_done     <= 1'b1;
                    end
                    `ECC_ADDR_DATA3: begin
                        data_in[`ECC_DATA_W-1:96] <= wb_dat_w[HI_W-1:0];
                        clear_done                <= 1'b1;
                    end
                    `ECC_ADDR_PAR_IN: begin
                        par_in     <= wb_dat_w[`ECC_PAR_W-1:0];
                        clear_done <= 1'b1;
                    end
                    `ECC_ADDR_CMD: begin
                        op     <= ecc_pkg::ecc_op_e'(wb_dat_w[`ECC_CMD_OP_BIT]);
                        cmd_wr <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_adr)
            `ECC_ADDR_DATA0:   rd_data = data_in[31:0];
            `ECC_ADDR_DATA1:   rd_data = data_in[63:32];
            `ECC_ADDR_DATA2:   rd_data = data_in[95:64];
            `ECC_ADDR_DATA3:   rd_data[HI_W-1:0] = data_in[`ECC_DATA_W-1:96];
            `ECC_ADDR_PAR_IN:  rd_data[`ECC_PAR_W-1:0] = par_in;
            `ECC_ADDR_CMD:     rd_data[`ECC_CMD_OP_BIT] = op;
            `ECC_ADDR_RES0:    rd_data = res_data[31:0];
            `ECC_ADDR_RES1:    rd_data = res_data[63:32];
            `ECC_ADDR_RES2:    rd_data = res_data[95:64];
            `ECC_ADDR_RES3:    rd_data[HI_W-1:0] = res_data[`ECC_DATA_W-1:96];
            `ECC_ADDR_RES_PAR: rd_data[`ECC_PAR_W-1:0] = res_par;
            `ECC_ADDR_STATUS: begin
                rd_data[`ECC_STAT_DONE_BIT] = done;
                rd_data[`ECC_STAT_SBIT_BIT] = sbit;
                rd_data[`ECC_STAT_DBIT_BIT] = dbit;
            end
            default: rd_data = '0;
        endcase
    end

    // Read data lands together with ack
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_dat_r <= '0;
        end else if (req && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

// File: hw/ecc_corrector.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_corrector (
    input  ecc_pkg::ecc_op_e op,
    input  ecc_pkg::data_t   data_in,
    input  ecc_pkg::parity_t par_in,
    input  ecc_pkg::parity_t par_gen,
    output ecc_pkg::data_t   data_out,
    output logic             sbit,
    output logic             dbit
);

    ecc_pkg::syndrome_t  syndrome;
    ecc_pkg::data_t      mask;
    ecc_pkg::syn_class_e syn_class;
    logic                is_check;

    assign syndrome = par_in ^ par_gen;
    assign is_check = (op == ecc_pkg::OP_CHECK);

    // At most one column can match
    always_comb begin
        mask = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            mask[i] = (syndrome == ecc_pkg::data_column(i));
        end
    end

    always_comb begin
        if (syndrome == '0) begin
            syn_class = ecc_pkg::SYN_CLEAN;
        end else if (|mask) begin
            syn_class = ecc_pkg::SYN_DATA;
        end else if ((syndrome & (syndrome - ecc_pkg::syndrome_t'(1))) == '0) begin
            syn_class = ecc_pkg::SYN_PARITY;  // Single bit set
        end else begin
            syn_class = ecc_pkg::SYN_DOUBLE;
        end
    end

    // Mask is all zero outside SYN_DATA
    assign data_out = is_check ? (data_in ^ mask) : data_in;

    assign sbit = is_check && ((syn_class == ecc_pkg::SYN_DATA) ||
                               (syn_class == ecc_pkg::SYN_PARITY));
    assign dbit = is_check && (syn_class == ecc_pkg::SYN_DOUBLE);

endmodule

// File: hw/ecc_encoder.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_encoder (
    input  ecc_pkg::data_t   data,
    output ecc_pkg::parity_t parity
);

    logic [`ECC_DATA_W-1:0] sel_mask [`ECC_PAR_W];  // Coverage per check bit

    // Constant after elaboration, one mask row per check bit
    always_comb begin
        ecc_pkg::syndrome_t col;
        col = '0;
        for (int j = 0; j < `ECC_PAR_W; j++) begin
            sel_mask[j] = '0;
        end
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            col = ecc_pkg::data_column(i);
            for (int j = 0; j < `ECC_PAR_W; j++) begin
                sel_mask[j][i] = col[j];
            end
        end
    end

    always_comb begin
        parity = '0;
        for (int j = 0; j < `ECC_PAR_W; j++) begin
            parity[j] = ^(data & sel_mask[j]);  // XOR tree over covered bits
        end
    end

endmodule

// File: hw/ecc_pkg.sv
`include "ecc_params.svh"

package ecc_pkg;

    typedef logic [`ECC_DATA_W-1:0] data_t;
    typedef logic [`ECC_PAR_W-1:0]  parity_t;
    typedef logic [`ECC_PAR_W-1:0]  syndrome_t;

    typedef enum logic {
        OP_ENCODE = 1'b0,  // Data passes, flags low
        OP_CHECK  = 1'b1
    } ecc_op_e;

    typedef enum logic [1:0] {
        SYN_CLEAN  = 2'd0,
        SYN_DATA   = 2'd1,
        SYN_PARITY = 2'd2,  // Error sits in a stored check bit
        SYN_DOUBLE = 2'd3
    } syn_class_e;

    // Hamming position in the low bits, top bit makes the column weight odd
    function automatic syndrome_t data_column(input int unsigned idx);
        int unsigned cnt;
        syndrome_t   col;
        cnt = 0;
        col = '0;
        for (int unsigned p = 3; p < (1 << (`ECC_PAR_W - 1)); p++) begin
            if ((p & (p - 1)) != 0) begin  // Skip powers of two
                if (cnt == idx) begin
                    col[`ECC_PAR_W-2:0] = p[`ECC_PAR_W-2:0];
                end
                cnt++;
            end
        end
        col[`ECC_PAR_W-1] = ~^col[`ECC_PAR_W-2:0];
        return col;
    endfunction

endpackage

// File: hw/ecc_params.svh
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

`define ECC_DATA_W        105
`define ECC_PAR_W         8
`define ECC_WB_AW         8
`define ECC_WB_DW         32

`define ECC_ADDR_DATA0    8'h00
`define ECC_ADDR_DATA1    8'h04
`define ECC_ADDR_DATA2    8'h08
`define ECC_ADDR_DATA3    8'h0C
`define ECC_ADDR_PAR_IN   8'h10
`define ECC_ADDR_CMD      8'h14
`define ECC_ADDR_RES0     8'h20
`define ECC_ADDR_RES1     8'h24
`define ECC_ADDR_RES2     8'h28
`define ECC_ADDR_RES3     8'h2C
`define ECC_ADDR_RES_PAR  8'h30
`define ECC_ADDR_STATUS   8'h34

`define ECC_CMD_OP_BIT    0
`define ECC_STAT_DONE_BIT 0
`define ECC_STAT_SBIT_BIT 1
`define ECC_STAT_DBIT_BIT 2

`endif
